// File: tb.f
hw/soc_interconnect_pkg.sv
hw/tcdm_addr_decoder.sv
hw/tcdm_bank_arbiter.sv
hw/tcdm_resp_router.sv
hw/soc_interconnect.sv
dv/tb_mem_model.sv
dv/tb_soc_interconnect.sv

// File: dv/tb_soc_interconnect.sv
`timescale 1ns/1ps

module tb_soc_interconnect;

    import soc_interconnect_pkg::*;

    localparam int unsigned CLK_PERIOD = 4;
    localparam int unsigned RST_CYCLES = 16;
    // Each word in the access phase costs three requests per master
    localparam int unsigned RW_WORDS  = 24;
    localparam int unsigned ERR_REQS  = 6;
    localparam int unsigned FAIR_REQS = 32;
    // The shared bank phase needs two cycles per request
    localparam int unsigned TIMEOUT_CYCLES =
        4 * (RST_CYCLES + 3 * RW_WORDS + ERR_REQS + 2 * FAIR_REQS);

    // SoC memory map with exclusive upper bounds
    localparam logic [31:0] INTLVD_LO = 32'h1C00_0000;
    localparam logic [31:0] INTLVD_HI = 32'h1C01_0000;
    localparam logic [31:0] CONTIG_LO = 32'h1C01_0000;
    localparam logic [31:0] CONTIG_HI = 32'h1C02_0000;
    localparam logic [31:0] ERR_WORD  = 32'hBADACCE5;

    logic clk   = 1'b0;
    logic rst_n = 1'b0;
    tcdm_req_t [NR_MASTERS-1:0] master_req;
    tcdm_rsp_t [NR_MASTERS-1:0] master_rsp;
    tcdm_req_t [NR_SLAVES-1:0]  slave_req;
    tcdm_rsp_t [NR_SLAVES-1:0]  slave_rsp;
    logic      [NR_SLAVES-1:0]  stall;
    logic [31:0] lfsr_state = 32'h2ceacddd;
    int unsigned cyc = 0;

    // Reference memory and the response due on each master port
    data_t ref_mem [addr_t];
    logic  [NR_MASTERS-1:0] exp_pend = '0;
    logic  [NR_MASTERS-1:0] exp_read = '0;
    logic  [NR_MASTERS-1:0] exp_opc  = '0;
    data_t [NR_MASTERS-1:0] exp_data;
    // Ports each master asks for and the ports it wins this cycle
    logic  [NR_MASTERS-1:0][NR_SLAVES-1:0] wants;
    logic  [NR_MASTERS-1:0][NR_SLAVES-1:0] won;

    soc_interconnect u_dut (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .master_req_i ( master_req ),
        .master_rsp_o ( master_rsp ),
        .slave_req_o  ( slave_req  ),
        .slave_rsp_i  ( slave_rsp  )
    );

    for (genvar s = 0; s < NR_SLAVES; s++) begin : gen_slave
        tb_mem_model u_mem (
            .clk_i   ( clk          ),
            .rst_n_i ( rst_n        ),
            .stall_i ( stall[s]     ),
            .req_i   ( slave_req[s] ),
            .rsp_o   ( slave_rsp[s] )
        );
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // Slave port that must serve an address or NR_SLAVES when it is unmapped
    function automatic int unsigned port_for_addr(logic [31:0] a);
        if (a >= INTLVD_LO && a < INTLVD_HI) begin
            return int'(a[2]);
        end
        if (a >= CONTIG_LO && a < CONTIG_HI) begin
            return 2;
        end
        return NR_SLAVES;
    endfunction

    // Word owned by master m
    // Address bit 3 keeps the words of the two masters apart
    function automatic addr_t pick_addr(int unsigned m, logic contig, logic bank);
        logic [31:0] r;
        r = rand_bits(12);
        return (contig ? CONTIG_LO : INTLVD_LO) | {16'h0, r[11:0], m[0], bank, 2'b00};
    endfunction

    task automatic mismatch_fatal(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    task automatic violation_fatal(string what);
        $display("Fail at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failed check");
    endtask

    // Puts one request on master m and holds it until the grant shows up
    task automatic issue(int unsigned m, addr_t add, logic wen, be_t be, data_t wdata);
        tcdm_req_t r;
        r.req   = 1'b1;
        r.add   = add;
        r.wen   = wen;
        r.be    = be;
        r.wdata = wdata;
        master_req[m] <= r;
        do begin
            @(posedge clk);
        end while (!master_rsp[m].gnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////////////////////////

    // Roughly one slave cycle in four is stalled
    always @(posedge clk) begin
        for (int s = 0; s < NR_SLAVES; s++) begin
            stall[s] <= (rand_bits(2) == 32'd3);
        end
    end

    // Every granted request books the response expected in the next cycle
    always @(posedge clk) begin
        addr_t wa;
        for (int m = 0; m < NR_MASTERS; m++) begin
            exp_pend[m] <= 1'b0;
            if (rst_n && master_req[m].req && master_rsp[m].gnt) begin
                wa = {master_req[m].add[31:2], 2'b00};
                exp_pend[m] <= 1'b1;
                exp_opc[m]  <= (port_for_addr(wa) == NR_SLAVES);
                if (port_for_addr(wa) == NR_SLAVES) begin
                    exp_read[m] <= master_req[m].wen;
                    exp_data[m] <= ERR_WORD;
                end else if (master_req[m].wen) begin
                    // Words never written carry no expectation
                    exp_read[m] <= (ref_mem.exists(wa) != 0);
                    exp_data[m] <= ref_mem.exists(wa) ? ref_mem[wa] : '0;
                end else begin
                    exp_read[m] <= 1'b0;
                    if (!ref_mem.exists(wa)) begin
                        ref_mem[wa] = '0;
                    end
                    for (int b = 0; b < 4; b++) begin
                        if (master_req[m].be[b]) begin
                            ref_mem[wa][8*b +: 8] = master_req[m].wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            for (int s = 0; s < NR_SLAVES; s++) begin
                wants[m][s] = master_req[m].req && (port_for_addr(master_req[m].add) == s);
                won[m][s]   = wants[m][s] && master_rsp[m].gnt;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_master_chk
        localparam int unsigned OTHER = NR_MASTERS - 1 - m;

        // Quiet master port in reset and in the first cycle after it
        a_reset_quiet : assert property (@(posedge clk)
            (cyc >= 1 && cyc <= RST_CYCLES) |-> (!master_rsp[m].gnt && !master_rsp[m].r_valid))
        else mismatch_fatal($sformatf("master_rsp[%0d].{gnt,r_valid}", m), 32'h0,
            {30'h0, $sampled(master_rsp[m].gnt), $sampled(master_rsp[m].r_valid)});

        // r_valid high in exactly the cycles that follow a grant
        a_rvalid_timing : assert property (@(posedge clk) disable iff (!rst_n)
            master_rsp[m].r_valid == exp_pend[m])
        else mismatch_fatal($sformatf("master_rsp[%0d].r_valid", m),
            32'($sampled(exp_pend[m])), 32'($sampled(master_rsp[m].r_valid)));

        a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
            (master_rsp[m].r_valid && exp_read[m]) |-> master_rsp[m].r_rdata == exp_data[m])
        else mismatch_fatal($sformatf("master_rsp[%0d].r_rdata", m),
            $sampled(exp_data[m]), $sampled(master_rsp[m].r_rdata));

        a_opc : assert property (@(posedge clk) disable iff (!rst_n)
            master_rsp[m].r_valid |-> master_rsp[m].r_opc == exp_opc[m])
        else mismatch_fatal($sformatf("master_rsp[%0d].r_opc", m),
            32'($sampled(exp_opc[m])), 32'($sampled(master_rsp[m].r_opc)));

        // The error responder never stalls
        a_error_grant : assert property (@(posedge clk) disable iff (!rst_n)
            (master_req[m].req && port_for_addr(master_req[m].add) == NR_SLAVES)
                |-> master_rsp[m].gnt)
        else violation_fatal($sformatf("unmapped request on master %0d not granted at once", m));

        // A master that just won a port cannot win it again while the other waits
        for (genvar s = 0; s < NR_SLAVES; s++) begin : gen_fair
            a_fair : assert property (@(posedge clk) disable iff (!rst_n)
                (won[m][s] && wants[OTHER][s]) |=> !won[m][s])
            else violation_fatal($sformatf("master %0d won port %0d twice in a row", m, s));
        end
    end

    // Banks only see their own interleaved words and port 2 only the contiguous region
    for (genvar s = 0; s < NR_SLAVES; s++) begin : gen_slave_chk
        a_port_range : assert property (@(posedge clk) disable iff (!rst_n)
            slave_req[s].req |-> port_for_addr(slave_req[s].add) == s)
        else violation_fatal($sformatf("slave port %0d got address %h outside its range",
            s, $sampled(slave_req[s].add)));
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Full write, partial overwrite and read back in both regions and banks
    // Then unmapped accesses with a write first and reads after it
    task automatic access_phase(int unsigned m);
        addr_t a;
        for (int unsigned i = 0; i < RW_WORDS; i++) begin
            a = pick_addr(m, i[1], i[0]);
            issue(m, a, 1'b0, 4'hF, rand_bits(32));
            issue(m, a, 1'b0, be_t'(rand_bits(4)), rand_bits(32));
            issue(m, a, 1'b1, 4'h0, '0);
        end
        for (int unsigned i = 0; i < ERR_REQS; i++) begin
            a = i[0] ? (32'h1C02_0000 | (rand_bits(14) << 2)) : (rand_bits(14) << 2);
            issue(m, a, (i != 0), 4'hF, rand_bits(32));
        end
        master_req[m] <= '0;
    endtask

    // Both masters hammer bank 0 back to back
    task automatic shared_bank_phase(int unsigned m);
        addr_t a;
        for (int unsigned i = 0; i < FAIR_REQS / 2; i++) begin
            a = pick_addr(m, 1'b0, 1'b0);
            issue(m, a, 1'b0, 4'hF, rand_bits(32));
            issue(m, a, 1'b1, 4'h0, '0);
        end
        master_req[m] <= '0;
    endtask

    initial begin
        master_req = '0;
        stall      = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        fork
            access_phase(0);
            access_phase(1);
        join
        fork
            shared_bank_phase(0);
            shared_bank_phase(1);
        join
        // Give the last responses time to be checked
        repeat (2) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        violation_fatal($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
    end

endmodule

// File: dv/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Holds gnt low in the current cycle
    input  logic                            stall_i,
    input  soc_interconnect_pkg::tcdm_req_t req_i,
    output soc_interconnect_pkg::tcdm_rsp_t rsp_o
);

    import soc_interconnect_pkg::*;

    // Sparse storage keyed by word address
    data_t mem [addr_t];

    logic  gnt;
    logic  rvalid_q;
    data_t rdata_q;
    addr_t word_add;

    // Content of a word that was never written, every address bit takes part
    function automatic data_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    assign word_add = {req_i.add[31:2], 2'b00};

    // A grant promises r_valid in the next cycle, so only stall draws can hold it off
    assign gnt = req_i.req && !stall_i;

    always @(posedge clk_i) begin
        data_t word;
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= gnt;
            if (gnt) begin
                word = mem.exists(word_add) ? mem[word_add] : fill_word(word_add);
                // Read data is the word as it was before this access
                rdata_q <= word;
                if (!req_i.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req_i.be[b]) begin
                            word[8*b +: 8] = req_i.wdata[8*b +: 8];
                        end
                    end
                    mem[word_add] = word;
                end
            end
        end
    end

    always_comb begin
        rsp_o.gnt     = gnt;
        rsp_o.r_valid = rvalid_q;
        rsp_o.r_rdata = rdata_q;
        rsp_o.r_opc   = 1'b0;
    end

endmodule

// File: hw/soc_interconnect.sv
`timescale 1ns/1ps

module soc_interconnect (
    input  logic                                                           clk_i,
    input  logic                                                           rst_n_i,
    // Master side
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_rsp_o,
    // Slave side, banks first and the contiguous slave last
    output soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_SLAVES-1:0]  slave_req_o,
    input  soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_SLAVES-1:0]  slave_rsp_i
);

    import soc_interconnect_pkg::*;

    // Decoded route of every master
    route_t [NR_MASTERS-1:0] route;

    // Requests seen by each arbiter, one bit per master
    logic [NR_SLAVES-1:0][NR_MASTERS-1:0] arb_req;
    // Grants from each arbiter, one-hot over masters
    logic [NR_SLAVES-1:0][NR_MASTERS-1:0] arb_grant;
    // Same grants regrouped per master, one bit per slave port
    logic [NR_MASTERS-1:0][NR_SLAVES-1:0] rtr_grant;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // One decoder per master, purely combinational
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_decoder
        tcdm_addr_decoder i_decoder (
            .master_req_i ( master_req_i[m] ),
            .route_o      ( route[m]        )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Request fan-out and grant transpose
    //////////////////////////////////////////////////////////////////////

    // A master asks port s only if its route is valid and points there
    // The error target never shows up here because its route is not valid
    for (genvar s = 0; s < NR_SLAVES; s++) begin : gen_req_slave
        for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_req_master
            assign arb_req[s][m]   = route[m].valid && (route[m].slave == slave_idx_t'(s));
            assign rtr_grant[m][s] = arb_grant[s][m];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Slave port arbitration
    //////////////////////////////////////////////////////////////////////

    // Banks and the contiguous slave share the same round-robin arbiter
    for (genvar s = 0; s < NR_SLAVES; s++) begin : gen_arbiter
        tcdm_bank_arbiter i_arbiter (
            .clk_i        ( clk_i          ),
            .rst_n_i      ( rst_n_i        ),
            .req_i        ( arb_req[s]     ),
            .master_req_i ( master_req_i   ),
            .slave_rsp_i  ( slave_rsp_i[s] ),
            .slave_req_o  ( slave_req_o[s] ),
            .grant_o      ( arb_grant[s]   )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Response routing
    //////////////////////////////////////////////////////////////////////

    // Each router also hosts the error responder for its master
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_router
        tcdm_resp_router i_router (
            .clk_i        ( clk_i           ),
            .rst_n_i      ( rst_n_i         ),
            .route_i      ( route[m]        ),
            .master_req_i ( master_req_i[m] ),
            .grant_i      ( rtr_grant[m]    ),
            .slave_rsp_i  ( slave_rsp_i     ),
            .master_rsp_o ( master_rsp_o[m] )
        );
    end

endmodule

// File: hw/tcdm_resp_router.sv
`timescale 1ns/1ps

module tcdm_resp_router (
    input  logic                                                        clk_i,
    input  logic                                                        rst_n_i,
    input  soc_interconnect_pkg::route_t                                route_i,
    input  soc_interconnect_pkg::tcdm_req_t                             master_req_i,
    input  logic [soc_interconnect_pkg::NR_SLAVES-1:0]                  grant_i,
    input  soc_interconnect_pkg::tcdm_rsp_t [soc_interconnect_pkg::NR_SLAVES-1:0] slave_rsp_i,
    output soc_interconnect_pkg::tcdm_rsp_t                             master_rsp_o
);

    import soc_interconnect_pkg::*;

    // Unmapped request, served by the local error responder
    logic       err_req;
    // Grant seen by the master this cycle
    logic       gnt;
    // A response is due in the current cycle
    logic       pending_q;
    // The due response comes from the error responder
    logic       err_q;
    // Slave port that granted last cycle
    slave_idx_t slave_q;

    //////////////////////////////////////////////////////////////////////
    // Grant
    //////////////////////////////////////////////////////////////////////

    // The error responder never stalls, so it grants in the request cycle
    assign err_req = master_req_i.req && (route_i.target == TGT_ERROR);

    // At most one arbiter can grant us, since the route points at a single port
    assign gnt = (|grant_i) || err_req;

    //////////////////////////////////////////////////////////////////////
    // Response bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            pending_q <= gnt;
            err_q     <= err_req;
        end
    end

    // Only looked at while pending_q is set
    always_ff @(posedge clk_i) begin
        if (gnt) begin
            slave_q <= route_i.slave;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        master_rsp_o.gnt = gnt;
        if (err_q) begin
            // Error word with the opc flag, for reads and writes alike
            master_rsp_o.r_valid = pending_q;
            master_rsp_o.r_rdata = ERROR_RESPONSE;
            master_rsp_o.r_opc   = 1'b1;
        end else begin
            // Pass the granting slave's answer through unchanged
            master_rsp_o.r_valid = pending_q && slave_rsp_i[slave_q].r_valid;
            master_rsp_o.r_rdata = slave_rsp_i[slave_q].r_rdata;
            master_rsp_o.r_opc   = slave_rsp_i[slave_q].r_opc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Every grant, from a slave or from the error responder, yields r_valid next cycle
    // This catches a slave that grants without being able to answer in time
    a_gnt_then_rvalid : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        master_rsp_o.gnt |=> master_rsp_o.r_valid
    ) else $error("grant without r_valid one cycle later");

endmodule

// File: hw/tcdm_bank_arbiter.sv
`timescale 1ns/1ps

module tcdm_bank_arbiter (
    input  logic                                                         clk_i,
    input  logic                                                         rst_n_i,
    input  logic [soc_interconnect_pkg::NR_MASTERS-1:0]                  req_i,
    input  soc_interconnect_pkg::tcdm_req_t [soc_interconnect_pkg::NR_MASTERS-1:0] master_req_i,
    input  soc_interconnect_pkg::tcdm_rsp_t                              slave_rsp_i,
    output soc_interconnect_pkg::tcdm_req_t                              slave_req_o,
    output logic [soc_interconnect_pkg::NR_MASTERS-1:0]                  grant_o
);

    import soc_interconnect_pkg::*;

    // Round-robin pointer, the master with the highest priority
    master_idx_t rr_ptr_q;
    // Chosen master and whether anyone requests at all
    master_idx_t pick;
    logic        pick_valid;
    // A transfer completes when the slave grants the chosen request
    logic        xfer;

    //////////////////////////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////////////////////////

    // Scan all masters starting at the pointer, first requester wins
    always_comb begin
        master_idx_t idx;

        pick       = rr_ptr_q;
        pick_valid = 1'b0;
        for (int unsigned off = 0; off < NR_MASTERS; off++) begin
            idx = master_idx_t'((int'(rr_ptr_q) + off) % NR_MASTERS);
            if (!pick_valid && req_i[idx]) begin
                pick       = idx;
                pick_valid = 1'b1;
            end
        end
    end

    // The request fields follow the chosen master
    // req itself must come from the route, since that master may target another port
    always_comb begin
        slave_req_o     = master_req_i[pick];
        slave_req_o.req = pick_valid;
    end

    assign xfer = pick_valid && slave_rsp_i.gnt;

    // A stalled slave leaves every grant bit low
    always_comb begin
        grant_o       = '0;
        grant_o[pick] = xfer;
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer update
    //////////////////////////////////////////////////////////////////////

    // Move past the winner only on a real transfer
    // Under back-pressure the waiting master keeps its priority
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
        end else if (xfer) begin
            rr_ptr_q <= master_idx_t'((int'(pick) + 1) % NR_MASTERS);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // At most one master wins the port per cycle
    a_grant_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant_o)
    ) else $error("grant vector not one-hot: %b", grant_o);

    // Never grant a master that does not want this port
    a_grant_has_req : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (grant_o & ~req_i) == '0
    ) else $error("grant %b without request %b", grant_o, req_i);

endmodule

// File: hw/tcdm_addr_decoder.sv
`timescale 1ns/1ps

module tcdm_addr_decoder (
    input  soc_interconnect_pkg::tcdm_req_t master_req_i,
    output soc_interconnect_pkg::route_t    route_o
);

    import soc_interconnect_pkg::*;

    // Region hits for the current address
    logic in_intlvd;
    logic in_contig;

    //////////////////////////////////////////////////////////////////////
    // Region match
    //////////////////////////////////////////////////////////////////////

    // Both regions are half-open ranges so they never overlap
    assign in_intlvd = (master_req_i.add >= INTLVD_BASE) && (master_req_i.add < INTLVD_END);
    assign in_contig = (master_req_i.add >= CONTIG_BASE) && (master_req_i.add < CONTIG_END);

    //////////////////////////////////////////////////////////////////////
    // Target and port selection
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Default is the error responder, which has no slave port
        route_o.target = TGT_ERROR;
        route_o.slave  = '0;

        if (in_intlvd) begin
            route_o.target = TGT_INTLVD;
            // Consecutive words alternate between the banks
            route_o.slave  = slave_idx_t'(master_req_i.add[BANK_SEL_BIT +: BANK_IDX_W]);
        end else if (in_contig) begin
            route_o.target = TGT_CONTIG;
            route_o.slave  = slave_idx_t'(CONTIG_PORT);
        end

        // Only mapped requests reach an arbiter
        // The router answers the unmapped ones on its own
        route_o.valid = master_req_i.req && (route_o.target != TGT_ERROR);
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // There is no clock here, so the check samples on every input change
    // An interleaved target must be backed by the region bounds and land on a bank
    a_intlvd_in_region : assert property (
        @(master_req_i)
        (route_o.target == TGT_INTLVD) |->
            ((master_req_i.add >= INTLVD_BASE) &&
             (master_req_i.add < INTLVD_END) &&
             (int'(route_o.slave) < NR_BANKS))
    ) else $error("interleaved target outside region, add=%h", master_req_i.add);

endmodule

// File: hw/soc_interconnect_pkg.sv
package soc_interconnect_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths and port counts
    //////////////////////////////////////////////////////////////////////

    // Plain 32-bit TCDM bus, one word per transfer
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // Two masters compete for every slave port
    localparam int unsigned NR_MASTERS = 2;
    // Interleaved SRAM banks, these occupy slave ports 0 .. NR_BANKS-1
    localparam int unsigned NR_BANKS   = 2;
    // Banks plus the single contiguous slave
    localparam int unsigned NR_SLAVES  = 3;

    // Index widths, kept at one bit at least so the vectors stay legal
    localparam int unsigned MASTER_IDX_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;
    localparam int unsigned SLAVE_IDX_W  = (NR_SLAVES > 1) ? $clog2(NR_SLAVES) : 1;
    localparam int unsigned BANK_IDX_W   = (NR_BANKS > 1) ? $clog2(NR_BANKS) : 1;

    typedef logic [MASTER_IDX_W-1:0] master_idx_t;
    typedef logic [SLAVE_IDX_W-1:0]  slave_idx_t;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    // Interleaved region, end address is exclusive
    localparam addr_t INTLVD_BASE = 32'h1C00_0000;
    localparam addr_t INTLVD_END  = 32'h1C01_0000;
    // Contiguous region directly above it
    localparam addr_t CONTIG_BASE = 32'h1C01_0000;
    localparam addr_t CONTIG_END  = 32'h1C02_0000;

    // Lowest word address bit, picks the bank inside the interleaved region
    localparam int unsigned BANK_SEL_BIT = 2;
    // The contiguous slave sits right after the banks
    localparam int unsigned CONTIG_PORT  = NR_BANKS;

    // Read data returned for any unmapped access
    localparam data_t ERROR_RESPONSE = 32'hBADACCE5;

    // Coarse target of a request after decoding
    typedef enum logic [1:0] {
        TGT_INTLVD,
        TGT_CONTIG,
        TGT_ERROR
    } target_e;

    //////////////////////////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////////////////////////

    // Request direction, wen high means read
    typedef struct packed {
        logic  req;
        addr_t add;
        logic  wen;
        be_t   be;
        data_t wdata;
    } tcdm_req_t;

    // Response direction, r_* fields are valid one cycle after gnt
    typedef struct packed {
        logic  gnt;
        logic  r_valid;
        data_t r_rdata;
        logic  r_opc;
    } tcdm_rsp_t;

    // Decoder result for one master
    typedef struct packed {
        logic       valid;
        target_e    target;
        slave_idx_t slave;
    } route_t;

endpackage
